// File: Makefile
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sdCardCmd.f --top-module sdCardCmd

sim:
	verilator --binary --timing -f sdCardCmd.f --top-module sdCardCmdTb -o sdCardCmdSim
	./obj_dir/sdCardCmdSim | tee $(LOG)
	grep -qx '=== PASS ===' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sdCardCmd.f
src/sdCardPkg.sv
src/sdCmdReceiver.sv
src/sdCardState.sv
src/sdRespBuilder.sv
src/sdRespSender.sv
src/sdCardCmd.sv
tb/sdCardCmdTb.sv

// File: src/sdCardCmd.sv
`timescale 1ns/1ps

module sdCardCmd import sdCardPkg::*; (
    input  logic clk,
    input  logic rst_,
    input  logic cmdIn,
    output logic cmdOut,
    output logic cmdOe
);

    logic     cmdReq;
    logic     cmdAck;
    cmdIndexT cmdIndex;
    cmdArgT   cmdArg;
    logic     crcErr;
    logic     cmdLegal;
    logic     respNeeded;
    cmdArgT   cardStatus;
    logic     opReady;
    logic     cmdCommit;
    logic     respReq;
    logic     respAck;
    respBitsT respBits;
    respKindT respKind;

    sdCmdReceiver receiver (
        .clk      (clk),
        .rst_     (rst_),
        .cmdIn    (cmdIn),
        .cmdAck   (cmdAck),
        .cmdReq   (cmdReq),
        .cmdIndex (cmdIndex),
        .cmdArg   (cmdArg),
        .crcErr   (crcErr)
    );

    // Card state only feeds the status word here
    sdCardState cardFsm (
        .clk        (clk),
        .rst_       (rst_),
        .cmdIndex   (cmdIndex),
        .cmdArg     (cmdArg),
        .cmdCommit  (cmdCommit),
        .crcErr     (crcErr),
        .cmdLegal   (cmdLegal),
        .respNeeded (respNeeded),
        .cardState  (),
        .cardStatus (cardStatus),
        .opReady    (opReady)
    );

    sdRespBuilder builder (
        .clk        (clk),
        .rst_       (rst_),
        .cmdReq     (cmdReq),
        .cmdIndex   (cmdIndex),
        .cmdArg     (cmdArg),
        .cmdLegal   (cmdLegal),
        .respNeeded (respNeeded),
        .cardStatus (cardStatus),
        .opReady    (opReady),
        .respAck    (respAck),
        .cmdAck     (cmdAck),
        .cmdCommit  (cmdCommit),
        .respReq    (respReq),
        .respBits   (respBits),
        .respKind   (respKind)
    );

    sdRespSender sender (
        .clk      (clk),
        .rst_     (rst_),
        .respReq  (respReq),
        .respBits (respBits),
        .respKind (respKind),
        .respAck  (respAck),
        .cmdOut   (cmdOut),
        .cmdOe    (cmdOe)
    );

endmodule

// File: src/sdCardPkg.sv
package sdCardPkg;

    // ========================================================================
    // Frame geometry
    // ========================================================================
    localparam int CMD_BITS       = 48;
    localparam int LONG_RESP_BITS = 136;
    // Start, transmission, index and argument fall under the CRC7
    localparam int CRC_COVER_BITS = 40;
    // Idle cycles between taking a response and driving CMD
    localparam int RESP_GAP       = 2;

    typedef logic [5:0]                cmdIndexT;
    typedef logic [31:0]               cmdArgT;
    typedef logic [6:0]                crc7T;
    typedef logic [LONG_RESP_BITS-1:0] respBitsT;

    typedef enum logic [1:0] {
        respShortCrc,
        respShortNoCrc,
        respLong
    } respKindT;

    // Encodings as reported in CURRENT_STATE
    typedef enum logic [3:0] {
        cardIdle  = 4'd0,
        cardReady = 4'd1,
        cardIdent = 4'd2,
        cardStby  = 4'd3,
        cardTran  = 4'd4
    } cardStateT;

    // ========================================================================
    // Commands and card constants
    // ========================================================================
    localparam cmdIndexT CMD_GO_IDLE       = 6'd0;
    localparam cmdIndexT CMD_ALL_SEND_CID  = 6'd2;
    localparam cmdIndexT CMD_SEND_RCA      = 6'd3;
    localparam cmdIndexT CMD_SELECT        = 6'd7;
    localparam cmdIndexT CMD_SEND_IF_COND  = 6'd8;
    localparam cmdIndexT CMD_APP           = 6'd55;
    localparam cmdIndexT ACMD_SEND_OP_COND = 6'd41;
    // Index field of R2 and R3
    localparam cmdIndexT RESP_RSVD_INDEX   = 6'h3F;

    localparam logic [15:0]  CARD_RCA = 16'hAAAA;
    localparam logic [127:0] CARD_CID = 128'h0353_4453_5231_3238_808b_b79d_6601_4677;
    localparam logic [30:0]  CARD_OCR = 31'h00FF_8080;

    localparam int INIT_BUSY_POLLS = 2;
    localparam int POLL_CNT_BITS   = $clog2(INIT_BUSY_POLLS + 1);

    // Card status bits
    localparam int ST_COM_CRC_ERROR   = 23;
    localparam int ST_ILLEGAL_COMMAND = 22;
    localparam int ST_STATE_LSB       = 9;
    localparam int ST_READY_FOR_DATA  = 8;
    localparam int ST_APP_CMD         = 5;

    // One bit of CRC7, x^7 + x^3 + 1
    function automatic crc7T crc7Step(crc7T crc, logic bitIn);
        logic fb;
        fb = bitIn ^ crc[6];
        return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
    endfunction

endpackage

// File: src/sdCardState.sv
`timescale 1ns/1ps

module sdCardState import sdCardPkg::*; (
    input  logic      clk,
    input  logic      rst_,
    input  cmdIndexT  cmdIndex,
    input  cmdArgT    cmdArg,
    input  logic      cmdCommit,
    input  logic      crcErr,
    output logic      cmdLegal,
    output logic      respNeeded,
    output cardStateT cardState,
    output cmdArgT    cardStatus,
    output logic      opReady
);

    logic                     appCmd;
    logic                     crcErrFlag;
    logic                     illegalFlag;
    logic [POLL_CNT_BITS-1:0] pollCnt;
    logic                     rcaMatch;
    logic                     isAcmd41;

    assign rcaMatch = (cmdArg[31:16] == CARD_RCA);
    assign isAcmd41 = appCmd && (cmdIndex == ACMD_SEND_OP_COND);
    assign opReady  = (pollCnt == POLL_CNT_BITS'(INIT_BUSY_POLLS));

    // ========================================================================
    // Legality of the command on cmdIndex
    // ========================================================================
    always_comb begin
        cmdLegal   = 1'b0;
        respNeeded = 1'b1;
        if (isAcmd41) begin
            cmdLegal = (cardState == cardIdle);
        end else begin
            case (cmdIndex)
                CMD_GO_IDLE: begin
                    cmdLegal   = 1'b1;
                    respNeeded = 1'b0;
                end
                CMD_ALL_SEND_CID: cmdLegal = (cardState == cardReady);
                CMD_SEND_RCA:     cmdLegal = (cardState == cardIdent) || (cardState == cardStby);
                CMD_SELECT: begin
                    cmdLegal   = (cardState == cardStby);
                    // Another card's RCA, stay quiet
                    respNeeded = rcaMatch;
                end
                CMD_SEND_IF_COND, CMD_APP: cmdLegal = 1'b1;
                default: cmdLegal = 1'b0;
            endcase
        end
        if (!cmdLegal) respNeeded = 1'b0;
    end

    // Status as seen when the command arrived
    always_comb begin
        cardStatus                     = '0;
        cardStatus[ST_COM_CRC_ERROR]   = crcErrFlag;
        cardStatus[ST_ILLEGAL_COMMAND] = illegalFlag;
        cardStatus[ST_STATE_LSB +: 4]  = cardState;
        cardStatus[ST_READY_FOR_DATA]  = 1'b1;
        cardStatus[ST_APP_CMD]         = appCmd || (cmdIndex == CMD_APP);
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            cardState   <= cardIdle;
            appCmd      <= 1'b0;
            crcErrFlag  <= 1'b0;
            illegalFlag <= 1'b0;
            pollCnt     <= '0;
        end else begin
            if (cmdCommit) begin
                appCmd <= cmdLegal && (cmdIndex == CMD_APP);
                if (!cmdLegal) begin
                    illegalFlag <= 1'b1;
                end else if (cmdIndex == CMD_GO_IDLE) begin
                    cardState   <= cardIdle;
                    crcErrFlag  <= 1'b0;
                    illegalFlag <= 1'b0;
                    pollCnt     <= '0;
                end else begin
                    // Flags go out with this response
                    if (respNeeded) begin
                        crcErrFlag  <= 1'b0;
                        illegalFlag <= 1'b0;
                    end
                    if (isAcmd41) begin
                        if (opReady) cardState <= cardReady;
                        else pollCnt <= pollCnt + 1'b1;
                    end else begin
                        case (cmdIndex)
                            CMD_ALL_SEND_CID: cardState <= cardIdent;
                            CMD_SEND_RCA:     cardState <= cardStby;
                            CMD_SELECT:       if (rcaMatch) cardState <= cardTran;
                            default:          cardState <= cardState;
                        endcase
                    end
                end
            end
            if (crcErr) crcErrFlag <= 1'b1;
        end
    end

endmodule

// File: src/sdCmdReceiver.sv
`timescale 1ns/1ps

module sdCmdReceiver import sdCardPkg::*; (
    input  logic     clk,
    input  logic     rst_,
    input  logic     cmdIn,
    input  logic     cmdAck,
    output logic     cmdReq,
    output cmdIndexT cmdIndex,
    output cmdArgT   cmdArg,
    output logic     crcErr
);

    typedef enum logic [1:0] {
        rxIdle,
        rxShift,
        rxCheck,
        rxHold
    } rxStateT;

    rxStateT             rxState;
    logic [CMD_BITS-1:0] frame;
    logic [5:0]          bitCnt;
    crc7T                crc;
    logic                startSeen;
    logic                crcOk;
    logic                framingOk;

    // No start bit hunting while a handshake is still open
    assign startSeen = (rxState == rxIdle) && !cmdAck && !cmdIn;

    // Fields are taken straight from the frame, parked while cmdReq is up
    assign cmdIndex = frame[45:40];
    assign cmdArg   = frame[39:8];

    assign crcOk     = (frame[7:1] == crc);
    assign framingOk = !frame[47] && frame[46] && frame[0];

    always_ff @(posedge clk) begin
        if (startSeen || rxState == rxShift) begin
            frame <= {frame[CMD_BITS-2:0], cmdIn};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            rxState <= rxIdle;
            cmdReq  <= 1'b0;
            crcErr  <= 1'b0;
            bitCnt  <= '0;
            crc     <= '0;
        end else begin
            crcErr <= 1'b0;
            case (rxState)
                rxIdle: begin
                    if (startSeen) begin
                        bitCnt  <= 6'd1;
                        crc     <= crc7Step('0, cmdIn);
                        rxState <= rxShift;
                    end
                end
                rxShift: begin
                    bitCnt <= bitCnt + 1'b1;
                    if (bitCnt < 6'(CRC_COVER_BITS)) crc <= crc7Step(crc, cmdIn);
                    // End bit lands on this edge
                    if (bitCnt == 6'(CMD_BITS - 1)) rxState <= rxCheck;
                end
                rxCheck: begin
                    if (framingOk && crcOk) begin
                        cmdReq  <= 1'b1;
                        rxState <= rxHold;
                    end else begin
                        crcErr  <= !crcOk;
                        rxState <= rxIdle;
                    end
                end
                rxHold: begin
                    if (cmdAck) begin
                        cmdReq  <= 1'b0;
                        rxState <= rxIdle;
                    end
                end
                default: rxState <= rxIdle;
            endcase
        end
    end

endmodule

// File: src/sdRespBuilder.sv
`timescale 1ns/1ps

module sdRespBuilder import sdCardPkg::*; (
    input  logic     clk,
    input  logic     rst_,
    input  logic     cmdReq,
    input  cmdIndexT cmdIndex,
    input  cmdArgT   cmdArg,
    input  logic     cmdLegal,
    input  logic     respNeeded,
    input  cmdArgT   cardStatus,
    input  logic     opReady,
    input  logic     respAck,
    output logic     cmdAck,
    output logic     cmdCommit,
    output logic     respReq,
    output respBitsT respBits,
    output respKindT respKind
);

    typedef enum logic [2:0] {
        bIdle,
        bNoResp,
        bRespWait,
        bRespDrop,
        bAckWait
    } bStateT;

    bStateT      bState;
    respBitsT    packBits;
    respKindT    packKind;
    logic [15:0] condStatus;
    logic        sendResp;

    // Short frame left aligned, CRC field and end bit preset to ones
    function automatic respBitsT shortFrame(cmdIndexT idx, cmdArgT arg);
        return {2'b00, idx, arg, 8'hFF, {(LONG_RESP_BITS - CMD_BITS){1'b1}}};
    endfunction

    assign sendResp   = cmdLegal && respNeeded;
    // R6 condensed status, bits 23, 22, 19 and 12..0
    assign condStatus = {cardStatus[ST_COM_CRC_ERROR], cardStatus[ST_ILLEGAL_COMMAND],
                         cardStatus[19], cardStatus[12:0]};

    always_comb begin
        packKind = respShortCrc;
        case (cmdIndex)
            CMD_ALL_SEND_CID: begin
                packBits = {2'b00, RESP_RSVD_INDEX, CARD_CID};
                packKind = respLong;
            end
            CMD_SEND_RCA:     packBits = shortFrame(cmdIndex, {CARD_RCA, condStatus});
            CMD_SEND_IF_COND: packBits = shortFrame(cmdIndex, {20'd0, cmdArg[11:0]});
            ACMD_SEND_OP_COND: begin
                packBits = shortFrame(RESP_RSVD_INDEX, {opReady, CARD_OCR});
                packKind = respShortNoCrc;
            end
            // R1
            default: packBits = shortFrame(cmdIndex, cardStatus);
        endcase
    end

    always_ff @(posedge clk) begin
        if (bState == bIdle && cmdReq && sendResp) begin
            respBits <= packBits;
            respKind <= packKind;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            bState    <= bIdle;
            cmdAck    <= 1'b0;
            cmdCommit <= 1'b0;
            respReq   <= 1'b0;
        end else begin
            cmdCommit <= 1'b0;
            case (bState)
                bIdle: begin
                    if (cmdReq) begin
                        respReq <= sendResp;
                        bState  <= sendResp ? bRespWait : bNoResp;
                    end
                end
                bNoResp: begin
                    cmdAck    <= 1'b1;
                    cmdCommit <= 1'b1;
                    bState    <= bAckWait;
                end
                bRespWait: begin
                    if (respAck) begin
                        respReq <= 1'b0;
                        bState  <= bRespDrop;
                    end
                end
                bRespDrop: begin
                    if (!respAck) begin
                        cmdAck    <= 1'b1;
                        cmdCommit <= 1'b1;
                        bState    <= bAckWait;
                    end
                end
                bAckWait: begin
                    if (!cmdReq) begin
                        cmdAck <= 1'b0;
                        bState <= bIdle;
                    end
                end
                default: bState <= bIdle;
            endcase
        end
    end

endmodule

// File: src/sdRespSender.sv
`timescale 1ns/1ps

module sdRespSender import sdCardPkg::*; (
    input  logic     clk,
    input  logic     rst_,
    input  logic     respReq,
    input  respBitsT respBits,
    input  respKindT respKind,
    output logic     respAck,
    output logic     cmdOut,
    output logic     cmdOe
);

    typedef enum logic [1:0] {
        sIdle,
        sSend,
        sAck
    } sStateT;

    sStateT     sState;
    respBitsT   shiftReg;
    logic [7:0] bitCnt;
    logic [7:0] frameLen;
    logic [3:0] gapCnt;
    crc7T       crc;
    logic       crcField;
    logic       nextBit;

    // respKind is held by the builder for the whole handshake
    assign frameLen = (respKind == respLong) ? 8'(LONG_RESP_BITS) : 8'(CMD_BITS);
    assign crcField = (respKind == respShortCrc) && (bitCnt >= 8'(CRC_COVER_BITS));

    always_comb begin
        if (!crcField) nextBit = shiftReg[LONG_RESP_BITS-1];
        else if (bitCnt == 8'(CMD_BITS - 1)) nextBit = 1'b1;
        else nextBit = crc[6];
    end

    always_ff @(posedge clk) begin
        if (sState == sIdle && respReq) shiftReg <= respBits;
        else if (sState == sSend && gapCnt == '0) shiftReg <= shiftReg << 1;
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            sState  <= sIdle;
            respAck <= 1'b0;
            cmdOut  <= 1'b1;
            cmdOe   <= 1'b0;
            bitCnt  <= '0;
            gapCnt  <= '0;
            crc     <= '0;
        end else begin
            case (sState)
                sIdle: begin
                    if (respReq) begin
                        gapCnt <= 4'(RESP_GAP - 1);
                        bitCnt <= '0;
                        crc    <= '0;
                        sState <= sSend;
                    end
                end
                sSend: begin
                    if (gapCnt != '0) begin
                        gapCnt <= gapCnt - 1'b1;
                    end else if (bitCnt == frameLen) begin
                        cmdOe   <= 1'b0;
                        cmdOut  <= 1'b1;
                        respAck <= 1'b1;
                        sState  <= sAck;
                    end else begin
                        cmdOe  <= 1'b1;
                        cmdOut <= nextBit;
                        bitCnt <= bitCnt + 1'b1;
                        // Accumulate, then shift the remainder out
                        if (bitCnt < 8'(CRC_COVER_BITS)) crc <= crc7Step(crc, nextBit);
                        else crc <= {crc[5:0], 1'b0};
                    end
                end
                sAck: begin
                    if (!respReq) begin
                        respAck <= 1'b0;
                        sState  <= sIdle;
                    end
                end
                default: sState <= sIdle;
            endcase
        end
    end

endmodule

// File: tb/sdCardCmdTb.sv
`timescale 1ns/1ps

module sdCardCmdTb import sdCardPkg::*; ();

    localparam int RESP_TIMEOUT   = 200;
    localparam int SILENCE_CYCLES = 150;
    // Idle host cycles before each command so both handshakes can close
    localparam int CMD_GAP        = 16;

    logic     clk;
    logic     rst_;
    logic     cmdIn;
    wire      cmdOut;
    wire      cmdOe;
    respBitsT resp;
    int       errors;
    int       checks;
    int       tests;
    int       errBase;

    initial clk = 1'b0;
    always #20 clk = ~clk;

    sdCardCmd uut (
        .clk    (clk),
        .rst_   (rst_),
        .cmdIn  (cmdIn),
        .cmdOut (cmdOut),
        .cmdOe  (cmdOe)
    );

    // ========================================================================
    // Reference helpers
    // ========================================================================
    function automatic crc7T frameCrc(logic [39:0] head);
        crc7T crc;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            crc = crc7Step(crc, head[i]);
        end
        return crc;
    endfunction

    function automatic cmdArgT expStatus(cardStateT st, logic app, logic crcE, logic ill);
        cmdArgT s;
        s                     = '0;
        s[ST_COM_CRC_ERROR]   = crcE;
        s[ST_ILLEGAL_COMMAND] = ill;
        s[ST_STATE_LSB +: 4]  = st;
        s[ST_READY_FOR_DATA]  = 1'b1;
        s[ST_APP_CMD]         = app;
        return s;
    endfunction

    // R6 status field
    function automatic logic [15:0] condensed(cmdArgT s);
        return {s[23], s[22], s[19], s[12:0]};
    endfunction

    task automatic flagProblem(input string msg);
        $display("%0t: %s", $time, msg);
        errors++;
    endtask

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic checkIndex(input string name, input cmdIndexT got, input cmdIndexT exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkArg(input string name, input cmdArgT got, input cmdArgT exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkCrc(input string name, input crc7T got, input crc7T exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkLong(input string name, input respBitsT got, input respBitsT exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // ========================================================================
    // Host side of the CMD line
    // ========================================================================
    task automatic sendCmd(input cmdIndexT idx, input cmdArgT arg, input logic badCrc);
        logic [CMD_BITS-1:0] frame;
        crc7T                crc;
        crc = frameCrc({2'b01, idx, arg});
        if (badCrc) crc = crc ^ 7'h01;
        frame = {2'b01, idx, arg, crc, 1'b1};
        repeat (CMD_GAP) @(posedge clk);
        for (int i = CMD_BITS - 1; i >= 0; i--) begin
            @(posedge clk);
            cmdIn <= frame[i];
        end
        @(posedge clk);
        cmdIn <= 1'b1;
    endtask

    // Bits sampled on the falling edge land left aligned in resp
    task automatic getResp(input int nBits, input string what, output logic got);
        int waitCnt;
        got     = 1'b0;
        resp    = '0;
        waitCnt = 0;
        @(negedge clk);
        while (!cmdOe && waitCnt < RESP_TIMEOUT) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!cmdOe) begin
            flagProblem($sformatf("no response to %s within %0d cycles", what, RESP_TIMEOUT));
            return;
        end
        for (int i = 0; i < nBits; i++) begin
            if (!cmdOe) begin
                flagProblem($sformatf("%s response stopped after %0d bits", what, i));
                return;
            end
            resp[LONG_RESP_BITS-1-i] = cmdOut;
            @(negedge clk);
        end
        if (cmdOe) flagProblem($sformatf("%s response runs past %0d bits", what, nBits));
        got = 1'b1;
    endtask

    task automatic expectSilence(input string what);
        for (int i = 0; i < SILENCE_CYCLES; i++) begin
            @(negedge clk);
            if (cmdOe) begin
                flagProblem($sformatf("card answered %s, which needs no response", what));
                break;
            end
        end
    endtask

    // With crcOn clear the CRC field is all ones as in R3
    task automatic checkShort(input string what, input cmdIndexT expIdx,
                              input cmdArgT expArg, input logic crcOn);
        logic got;
        crc7T expCrc;
        getResp(CMD_BITS, what, got);
        if (!got) return;
        expCrc = crcOn ? frameCrc({2'b00, expIdx, expArg}) : 7'h7F;
        if (resp[135] !== 1'b0 || resp[134] !== 1'b0) begin
            flagProblem($sformatf("%s response has a wrong start or transmission bit", what));
        end
        checkIndex({what, " index"}, resp[133:128], expIdx);
        checkArg({what, " arg"}, resp[127:96], expArg);
        checkCrc({what, " crc"}, resp[95:89], expCrc);
        if (resp[88] !== 1'b1) flagProblem($sformatf("%s response lacks its end bit", what));
    endtask

    task automatic startTest();
        tests++;
        errBase = errors;
    endtask

    task automatic endTest(input string name);
        $display("%s: %s (%0d errors)", name, (errors == errBase) ? "ok" : "bad",
                 errors - errBase);
    endtask

    // ========================================================================
    // Tests
    // ========================================================================
    task automatic testIdleAndIfCond();
        startTest();
        sendCmd(CMD_GO_IDLE, '0, 1'b0);
        expectSilence("CMD0");
        sendCmd(CMD_SEND_IF_COND, 32'h0000_01AA, 1'b0);
        checkShort("CMD8", CMD_SEND_IF_COND, 32'h0000_01AA, 1'b1);
        endTest("go idle and interface condition");
    endtask

    task automatic testOpCond();
        logic ready;
        startTest();
        for (int poll = 0; poll <= INIT_BUSY_POLLS; poll++) begin
            ready = (poll == INIT_BUSY_POLLS);
            sendCmd(CMD_APP, '0, 1'b0);
            checkShort("CMD55", CMD_APP, expStatus(cardIdle, 1'b1, 1'b0, 1'b0), 1'b1);
            sendCmd(ACMD_SEND_OP_COND, 32'h40FF_8000, 1'b0);
            checkShort("ACMD41", 6'h3F, {ready, CARD_OCR}, 1'b0);
        end
        endTest("operating condition polling");
    endtask

    task automatic testIdent();
        logic got;
        startTest();
        sendCmd(CMD_ALL_SEND_CID, '0, 1'b0);
        getResp(LONG_RESP_BITS, "CMD2", got);
        if (got) checkLong("CMD2 frame", resp, {2'b00, 6'h3F, CARD_CID});
        sendCmd(CMD_SEND_RCA, '0, 1'b0);
        checkShort("CMD3", CMD_SEND_RCA,
                   {CARD_RCA, condensed(expStatus(cardIdent, 1'b0, 1'b0, 1'b0))}, 1'b1);
        endTest("CID and RCA");
    endtask

    task automatic testSelect();
        startTest();
        sendCmd(CMD_SELECT, 32'h1234_0000, 1'b0);
        expectSilence("CMD7 to another RCA");
        sendCmd(CMD_SELECT, {CARD_RCA, 16'h0000}, 1'b0);
        checkShort("CMD7", CMD_SELECT, expStatus(cardStby, 1'b0, 1'b0, 1'b0), 1'b1);
        sendCmd(CMD_APP, {CARD_RCA, 16'h0000}, 1'b0);
        checkShort("CMD55 in tran", CMD_APP, expStatus(cardTran, 1'b1, 1'b0, 1'b0), 1'b1);
        endTest("card select");
    endtask

    task automatic testErrorFlags();
        cmdArgT rcaArg;
        startTest();
        rcaArg = {CARD_RCA, 16'h0000};
        sendCmd(CMD_SEND_IF_COND, 32'h0000_01AA, 1'b1);
        expectSilence("CMD8 with a bad CRC");
        sendCmd(CMD_APP, rcaArg, 1'b0);
        checkShort("CMD55 after bad CRC", CMD_APP,
                   expStatus(cardTran, 1'b1, 1'b1, 1'b0), 1'b1);
        sendCmd(CMD_APP, rcaArg, 1'b0);
        checkShort("CMD55 CRC flag cleared", CMD_APP,
                   expStatus(cardTran, 1'b1, 1'b0, 1'b0), 1'b1);
        // CMD18 is not supported
        sendCmd(6'd18, '0, 1'b0);
        expectSilence("CMD18");
        sendCmd(CMD_APP, rcaArg, 1'b0);
        checkShort("CMD55 after CMD18", CMD_APP,
                   expStatus(cardTran, 1'b1, 1'b0, 1'b1), 1'b1);
        sendCmd(CMD_APP, rcaArg, 1'b0);
        checkShort("CMD55 illegal flag cleared", CMD_APP,
                   expStatus(cardTran, 1'b1, 1'b0, 1'b0), 1'b1);
        endTest("error flags");
    endtask

    initial begin
        rst_    = 1'b0;
        cmdIn   = 1'b1;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        errBase = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (cmdOe !== 1'b0 || cmdOut !== 1'b1) flagProblem("CMD line not released in reset");
        @(posedge clk);
        rst_ <= 1'b1;

        testIdleAndIfCond();
        testOpCond();
        testIdent();
        testSelect();
        testErrorFlags();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
